//--- sim.f
verilog/sort_pkg.sv
verilog/stream_fifo.sv
verilog/chunk_sorter.sv
verilog/merging_core.sv
verilog/merging_unit.sv
verilog/sorter_top.sv
dv/tb_clock_gen.sv
dv/sorter_assertions.sv
dv/sorter_tb.sv

//--- Makefile
TOP := sorter_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir

# The run passes only when the pass line shows up in the simulator output
run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir

//--- dv/sorter_tb.sv
// Testbench for the streaming merge sorter with a job table and a reference sort
`timescale 1ns/1ps
`default_nettype none

module sorter_tb;

    localparam int MAX_SORT_LENGTH = 32;
    localparam int BASE_CHUNK_SIZE = 8;
    localparam int DW              = sort_pkg::DATA_WIDTH;
    localparam int NUM_JOBS        = 15;

    localparam logic [2:0] PAT_RANDOM  = 3'd0;
    localparam logic [2:0] PAT_DESCEND = 3'd1;
    localparam logic [2:0] PAT_EQUAL   = 3'd2;
    localparam logic [2:0] PAT_EXTREME = 3'd3;
    // Replays the values of the previous row
    localparam logic [2:0] PAT_REPEAT  = 3'd4;

    typedef struct packed {
        logic [7:0] length;
        logic [2:0] pattern;
        logic [6:0] gap_pct;
        logic [6:0] stall_pct;
    } job_row_t;

    logic                 clock;
    logic                 arst_n;
    sort_pkg::sort_beat_t in_beat;
    logic                 in_valid;
    logic                 in_ready;
    sort_pkg::sort_beat_t out_beat;
    logic                 out_valid;
    logic                 out_ready;

    job_row_t      job_table [NUM_JOBS];
    logic [DW-1:0] job_vals [$];
    logic [DW-1:0] in_job_vals [$];
    logic [DW-1:0] exp_data [$];
    logic          exp_last [$];
    logic [31:0]   data_state;
    logic [31:0]   stall_state;
    int            errors = 0;
    int            out_count = 0;
    int            out_job = 0;
    int            total_elems = 0;
    int            cycle_count = 0;
    int            timeout_limit = 0;

    tb_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(5)) i_clock_gen (
        .clock(clock),
        .arst_n(arst_n)
    );

    sorter_top #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH),
        .BASE_CHUNK_SIZE(BASE_CHUNK_SIZE)
    ) i_dut (
        .clock(clock), .arst_n(arst_n),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fill_job_table();
        job_table[0]  = '{8'd32, PAT_RANDOM,  7'd0,  7'd0};
        job_table[1]  = '{8'd13, PAT_RANDOM,  7'd0,  7'd0};
        job_table[2]  = '{8'd17, PAT_RANDOM,  7'd0,  7'd0};
        job_table[3]  = '{8'd8,  PAT_RANDOM,  7'd0,  7'd0};
        job_table[4]  = '{8'd3,  PAT_RANDOM,  7'd0,  7'd0};
        job_table[5]  = '{8'd32, PAT_DESCEND, 7'd0,  7'd0};
        job_table[6]  = '{8'd20, PAT_EQUAL,   7'd0,  7'd0};
        job_table[7]  = '{8'd24, PAT_EXTREME, 7'd0,  7'd0};
        job_table[8]  = '{8'd24, PAT_RANDOM,  7'd0,  7'd0};
        job_table[9]  = '{8'd24, PAT_REPEAT,  7'd30, 7'd40};
        job_table[10] = '{8'd13, PAT_RANDOM,  7'd50, 7'd50};
        job_table[11] = '{8'd1,  PAT_RANDOM,  7'd20, 7'd20};
        job_table[12] = '{8'd32, PAT_EXTREME, 7'd25, 7'd60};
        job_table[13] = '{8'd16, PAT_RANDOM,  7'd0,  7'd0};
        job_table[14] = '{8'd32, PAT_RANDOM,  7'd0,  7'd0};
    endtask

    task automatic make_job_values(input job_row_t row);
        logic [DW-1:0] v;
        if (row.pattern != PAT_REPEAT) begin
            job_vals.delete();
            for (int i = 0; i < int'(row.length); i++) begin
                data_state = lcg_next(data_state);
                case (row.pattern)
                    PAT_RANDOM:  v = data_state;
                    PAT_DESCEND: v = DW'(int'(row.length) - i) * 32'd1000 + 32'd7;
                    PAT_EQUAL:   v = 32'h1234_5678;
                    default:     v = data_state[31] ? '1 : '0;
                endcase
                job_vals.push_back(v);
            end
        end
    endtask

    task automatic gap_cycles(input int pct);
        data_state = lcg_next(data_state);
        while (int'(data_state[31:16] % 16'd100) < pct) begin
            in_valid <= 1'b0;
            @(posedge clock);
            data_state = lcg_next(data_state);
        end
    endtask

    // Presents one beat and returns on the edge where it is accepted
    task automatic send_beat(input logic [DW-1:0] data, input logic last);
        in_beat.data <= data;
        in_beat.last <= last;
        in_valid     <= 1'b1;
        @(posedge clock);
        while (!in_ready) begin
            @(posedge clock);
        end
    endtask

    // Insertion sort of the job as it was accepted serves as the reference model
    task automatic queue_expected();
        logic [DW-1:0] sorted [$];
        logic [DW-1:0] v;
        int            pos;
        foreach (in_job_vals[i]) begin
            v   = in_job_vals[i];
            pos = 0;
            while (pos < sorted.size() && sorted[pos] <= v) begin
                pos++;
            end
            sorted.insert(pos, v);
        end
        foreach (sorted[i]) begin
            exp_data.push_back(sorted[i]);
            exp_last.push_back(i == sorted.size() - 1);
        end
        in_job_vals.delete();
    endtask

    task automatic check_out_beat();
        logic [DW-1:0] exp_d;
        logic          exp_l;
        assert (exp_data.size() != 0) else begin
            errors++;
            $display("output beat %h came out with no input job waiting for it", out_beat.data);
        end
        if (exp_data.size() != 0) begin
            exp_d = exp_data.pop_front();
            exp_l = exp_last.pop_front();
            assert (out_beat.data == exp_d) else begin
                errors++;
                $display("mismatch out_beat.data: expected %h, got %h", exp_d, out_beat.data);
            end
            assert (out_beat.last == exp_l) else begin
                errors++;
                $display("mismatch out_beat.last: expected %h, got %h", exp_l, out_beat.last);
            end
            out_count++;
            if (exp_l) begin
                out_job++;
            end
        end
    endtask

    task automatic finish_run();
        $display("Run ended after %0d cycles with %0d of %0d beats checked and %0d errors",
                 cycle_count, out_count, total_elems, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    // Captures input beats, checks output beats and draws out_ready stalls on each rising edge
    always @(posedge clock) begin
        if (arst_n) begin
            if (in_valid && in_ready) begin
                in_job_vals.push_back(in_beat.data);
                if (in_beat.last) begin
                    queue_expected();
                end
            end
            if (out_valid && out_ready) begin
                check_out_beat();
            end
            stall_state = lcg_next(stall_state);
            if (out_job < NUM_JOBS) begin
                out_ready <= int'(stall_state[31:16] % 16'd100) >=
                             int'(job_table[out_job].stall_pct);
            end else begin
                out_ready <= 1'b1;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_limit) begin
            errors++;
            $display("timeout with %0d of %0d output beats seen", out_count, total_elems);
            finish_run();
        end
    end

    initial begin
        in_valid    = 1'b0;
        in_beat     = '0;
        out_ready   = 1'b0;
        data_state  = 32'h66aa;
        stall_state = 32'h66aa;
        fill_job_table();
        foreach (job_table[j]) begin
            total_elems += int'(job_table[j].length);
        end
        timeout_limit = 40 * total_elems + 1000;

        while (!arst_n) begin
            @(posedge clock);
        end
        @(posedge clock);

        // Jobs go in back to back and only the row's gap setting spaces the beats
        for (int j = 0; j < NUM_JOBS; j++) begin
            make_job_values(job_table[j]);
            for (int i = 0; i < job_vals.size(); i++) begin
                gap_cycles(int'(job_table[j].gap_pct));
                send_beat(job_vals[i], i == job_vals.size() - 1);
            end
        end
        in_valid <= 1'b0;

        while (out_count < total_elems) begin
            @(posedge clock);
        end
        repeat (20) @(posedge clock);
        finish_run();
    end

endmodule

`default_nettype wire

//--- dv/sorter_assertions.sv
// Handshake and reset assertions for the merging unit, attached with bind
`timescale 1ns/1ps
`default_nettype none

module sorter_assertions (
    input logic                 clock,
    input logic                 arst_n,
    input sort_pkg::sort_beat_t out_beat,
    input logic                 out_valid,
    input logic                 out_ready,
    input logic                 core_start,
    input logic                 merge_done
);

    // Tracks a merge from its start pulse to its done pulse
    logic merge_busy;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            merge_busy <= 1'b0;
        end else if (core_start) begin
            merge_busy <= 1'b1;
        end else if (merge_done) begin
            merge_busy <= 1'b0;
        end
    end

    out_quiet_in_reset: assert property (@(posedge clock) !arst_n |-> !out_valid)
        else $error("out_valid high while reset is asserted");

    out_held_on_stall: assert property (@(posedge clock) disable iff (!arst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
        else $error("stalled output beat changed or was withdrawn");

    start_only_when_idle: assert property (@(posedge clock) disable iff (!arst_n)
        core_start |-> !merge_busy)
        else $error("merge start raised while a merge is active");

    done_only_when_busy: assert property (@(posedge clock) disable iff (!arst_n)
        merge_done |-> merge_busy)
        else $error("merge done pulsed with no merge running");

endmodule

bind merging_unit sorter_assertions i_sorter_assertions (
    .clock(clock),
    .arst_n(arst_n),
    .out_beat(out_beat),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .core_start(core_start),
    .merge_done(merge_done)
);

`default_nettype wire

//--- dv/tb_clock_gen.sv
// Testbench clock and reset generator with a 40 ns period and a 5-cycle reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 5
) (
    output logic clock,
    output logic arst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    // Release on a rising edge so the first active cycle is a full one
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        arst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verilog/sorter_top.sv
// Streaming merge sorter top level joining the chunk sorter to the merging unit
`timescale 1ns/1ps
`default_nettype none

module sorter_top #(
    parameter int MAX_SORT_LENGTH = 32,
    parameter int BASE_CHUNK_SIZE = 8
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  sort_pkg::sort_beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output sort_pkg::sort_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    sort_pkg::sort_beat_t chunk_beat;
    sort_pkg::job_desc_t  desc;

    logic chunk_valid;
    logic chunk_ready;
    logic desc_valid;
    logic desc_ready;

    chunk_sorter #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH),
        .BASE_CHUNK_SIZE(BASE_CHUNK_SIZE)
    ) i_chunk_sorter (
        .clock(clock), .arst_n(arst_n),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .chunk_beat(chunk_beat), .chunk_valid(chunk_valid), .chunk_ready(chunk_ready),
        .desc(desc), .desc_valid(desc_valid), .desc_ready(desc_ready)
    );

    merging_unit #(
        .MAX_SORT_LENGTH(MAX_SORT_LENGTH),
        .BASE_CHUNK_SIZE(BASE_CHUNK_SIZE)
    ) i_merging_unit (
        .clock(clock), .arst_n(arst_n),
        .chunk_beat(chunk_beat), .chunk_valid(chunk_valid), .chunk_ready(chunk_ready),
        .desc(desc), .desc_valid(desc_valid), .desc_ready(desc_ready),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

`default_nettype wire

//--- verilog/merging_unit.sv
// Merging unit that stacks sorted chunks in a result FIFO and merges each new chunk into it
`timescale 1ns/1ps
`default_nettype none

module merging_unit #(
    parameter int MAX_SORT_LENGTH = 32,
    parameter int BASE_CHUNK_SIZE = 8
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  sort_pkg::sort_beat_t chunk_beat,
    input  logic                 chunk_valid,
    output logic                 chunk_ready,
    input  sort_pkg::job_desc_t  desc,
    input  logic                 desc_valid,
    output logic                 desc_ready,
    output sort_pkg::sort_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready
);

    sort_pkg::merge_state_e state;

    sort_pkg::sort_beat_t fin_beat;
    sort_pkg::sort_beat_t fb_beat;
    sort_pkg::sort_beat_t merge_beat;
    sort_pkg::sort_beat_t res_in_beat;

    logic fin_valid, fin_ready;
    logic fb_valid, fb_ready;
    logic merge_valid, merge_ready;
    logic res_in_valid, res_in_ready;
    logic core_b_ready;
    logic core_start;
    logic merge_done;
    logic select_bypass;
    logic output_selector;
    logic bypass_ready;

    logic        single_job;
    logic [15:0] chunks_to_merge;
    logic [15:0] last_size;
    logic [15:0] input_chunk_size;
    logic [15:0] result_size;

    stream_fifo #(.DEPTH(MAX_SORT_LENGTH)) input_fifo (
        .clock(clock), .arst_n(arst_n),
        .in_beat(chunk_beat), .in_valid(chunk_valid), .in_ready(chunk_ready),
        .out_beat(fin_beat), .out_valid(fin_valid), .out_ready(fin_ready)
    );

    stream_fifo #(.DEPTH(MAX_SORT_LENGTH)) result_fifo (
        .clock(clock), .arst_n(arst_n),
        .in_beat(res_in_beat), .in_valid(res_in_valid), .in_ready(res_in_ready),
        .out_beat(fb_beat), .out_valid(fb_valid), .out_ready(fb_ready)
    );

    merging_core #(.MAX_SORT_LENGTH(MAX_SORT_LENGTH)) i_merge_core (
        .clock(clock), .arst_n(arst_n), .start(core_start),
        .chunk_a_size(result_size), .chunk_b_size(input_chunk_size),
        .a_beat(fb_beat), .a_valid(fb_valid), .a_ready(fb_ready),
        .b_beat(fin_beat), .b_valid(fin_valid && !select_bypass), .b_ready(core_b_ready),
        .out_beat(merge_beat), .out_valid(merge_valid), .out_ready(merge_ready),
        .merge_done(merge_done)
    );

    // The final merge of a job goes to the output, earlier ones back into result_fifo
    assign select_bypass   = state == sort_pkg::merge_bypass;
    assign output_selector = chunks_to_merge == 16'd1;
    assign desc_ready      = state == sort_pkg::merge_idle;

    assign bypass_ready = single_job ? out_ready : res_in_ready;
    assign fin_ready    = select_bypass ? bypass_ready : core_b_ready;
    assign merge_ready  = output_selector ? out_ready : res_in_ready;

    assign res_in_beat  = select_bypass ? fin_beat : merge_beat;
    assign res_in_valid = select_bypass ? (fin_valid && !single_job) :
                          (merge_valid && !output_selector);

    assign out_beat  = select_bypass ? fin_beat : merge_beat;
    assign out_valid = select_bypass ? (fin_valid && single_job) :
                       (merge_valid && output_selector);

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state            <= sort_pkg::merge_idle;
            core_start       <= 1'b0;
            single_job       <= 1'b0;
            chunks_to_merge  <= '0;
            last_size        <= '0;
            input_chunk_size <= '0;
            result_size      <= '0;
        end else begin
            core_start <= 1'b0;
            case (state)
                sort_pkg::merge_idle: begin
                    if (desc_valid) begin
                        single_job       <= desc.single;
                        chunks_to_merge  <= desc.n_chunks;
                        last_size        <= desc.last_chunk_size;
                        result_size      <= 16'(BASE_CHUNK_SIZE);
                        input_chunk_size <= 16'(BASE_CHUNK_SIZE);
                        if (desc.n_chunks == 16'd1 && desc.last_chunk_size != '0) begin
                            input_chunk_size <= desc.last_chunk_size;
                        end
                        state <= sort_pkg::merge_bypass;
                    end
                end
                sort_pkg::merge_bypass: begin
                    // The first chunk ends on its last flag
                    if (fin_valid && fin_ready && fin_beat.last) begin
                        if (single_job) begin
                            state <= sort_pkg::merge_idle;
                        end else begin
                            core_start <= 1'b1;
                            state      <= sort_pkg::merge_merging;
                        end
                    end
                end
                sort_pkg::merge_merging: begin
                    if (merge_done) begin
                        chunks_to_merge <= chunks_to_merge - 1'b1;
                        state           <= sort_pkg::merge_update_sizes;
                    end
                end
                default: begin
                    result_size <= result_size + input_chunk_size;
                    if (chunks_to_merge == 16'd1 && last_size != '0) begin
                        input_chunk_size <= last_size;
                    end
                    if (chunks_to_merge == '0) begin
                        state <= sort_pkg::merge_idle;
                    end else begin
                        core_start <= 1'b1;
                        state      <= sort_pkg::merge_merging;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/merging_core.sv
// Merge core that joins two sorted streams of known lengths into one ascending stream
`timescale 1ns/1ps
`default_nettype none

module merging_core #(
    parameter int MAX_SORT_LENGTH = 32
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  logic                 start,
    input  logic [15:0]          chunk_a_size,
    input  logic [15:0]          chunk_b_size,
    input  sort_pkg::sort_beat_t a_beat,
    input  logic                 a_valid,
    output logic                 a_ready,
    input  sort_pkg::sort_beat_t b_beat,
    input  logic                 b_valid,
    output logic                 b_ready,
    output sort_pkg::sort_beat_t out_beat,
    output logic                 out_valid,
    input  logic                 out_ready,
    output logic                 merge_done
);

    localparam int CNT_W = $clog2(MAX_SORT_LENGTH + 1);

    logic [CNT_W-1:0] rem_a;
    logic [CNT_W-1:0] rem_b;
    logic [CNT_W:0]   total;
    logic             active;
    logic             a_left;
    logic             b_left;
    logic             sel_a;
    logic             out_fire;
    logic             final_beat;

    assign a_left     = rem_a != '0;
    assign b_left     = rem_b != '0;
    assign total      = {1'b0, rem_a} + {1'b0, rem_b};
    assign final_beat = total == (CNT_W + 1)'(1);

    // Both heads must be present to compare, and ties go to stream A
    always_comb begin
        if (a_left && b_left) begin
            out_valid = active && a_valid && b_valid;
            sel_a     = a_beat.data <= b_beat.data;
        end else if (a_left) begin
            out_valid = active && a_valid;
            sel_a     = 1'b1;
        end else begin
            out_valid = active && b_left && b_valid;
            sel_a     = 1'b0;
        end
    end

    assign out_beat.data = sel_a ? a_beat.data : b_beat.data;
    assign out_beat.last = final_beat;

    assign out_fire = out_valid && out_ready;
    assign a_ready  = out_fire && sel_a;
    assign b_ready  = out_fire && !sel_a;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rem_a      <= '0;
            rem_b      <= '0;
            active     <= 1'b0;
            merge_done <= 1'b0;
        end else begin
            merge_done <= out_fire && final_beat;
            if (start) begin
                rem_a  <= chunk_a_size[CNT_W-1:0];
                rem_b  <= chunk_b_size[CNT_W-1:0];
                active <= 1'b1;
            end else if (out_fire) begin
                if (sel_a) begin
                    rem_a <= rem_a - 1'b1;
                end else begin
                    rem_b <= rem_b - 1'b1;
                end
                if (final_beat) begin
                    active <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/chunk_sorter.sv
// Chunk sorter that sorts base chunks by odd-even transposition and builds the job descriptor
`timescale 1ns/1ps
`default_nettype none

module chunk_sorter #(
    parameter int MAX_SORT_LENGTH = 32,
    parameter int BASE_CHUNK_SIZE = 8
) (
    input  logic                 clock,
    input  logic                 arst_n,
    input  sort_pkg::sort_beat_t in_beat,
    input  logic                 in_valid,
    output logic                 in_ready,
    output sort_pkg::sort_beat_t chunk_beat,
    output logic                 chunk_valid,
    input  logic                 chunk_ready,
    output sort_pkg::job_desc_t  desc,
    output logic                 desc_valid,
    input  logic                 desc_ready
);

    localparam int IDX_W   = $clog2(BASE_CHUNK_SIZE);
    localparam int CHUNK_W = $clog2(MAX_SORT_LENGTH / BASE_CHUNK_SIZE + 1);

    sort_pkg::chunk_state_e state;

    logic [sort_pkg::DATA_WIDTH-1:0] arr [BASE_CHUNK_SIZE];
    logic [sort_pkg::DATA_WIDTH-1:0] sorted_next [BASE_CHUNK_SIZE];

    logic [IDX_W-1:0]   cnt;
    logic [IDX_W:0]     chunk_len;
    logic [IDX_W-1:0]   pass_cnt;
    logic [IDX_W-1:0]   drain_idx;
    logic [CHUNK_W-1:0] chunk_count;
    logic               in_fire;
    logic               chunk_end;
    logic               drain_fire;

    // A pending descriptor holds off the next job until the merging unit takes it
    assign in_ready  = (state == sort_pkg::chunk_collect) && !desc_valid;
    assign in_fire   = in_valid && in_ready;
    assign chunk_end = in_beat.last || (cnt == IDX_W'(BASE_CHUNK_SIZE - 1));

    assign chunk_valid     = state == sort_pkg::chunk_drain;
    assign chunk_beat.data = arr[drain_idx];
    assign chunk_beat.last = {1'b0, drain_idx} == chunk_len - 1'b1;
    assign drain_fire      = chunk_valid && chunk_ready;

    // One transposition pass compares even pairs on even passes and odd pairs on odd passes
    always_comb begin
        sorted_next = arr;
        for (int i = 0; i < BASE_CHUNK_SIZE - 1; i++) begin
            if ((i % 2) == int'(pass_cnt[0]) && arr[i] > arr[i+1]) begin
                sorted_next[i]   = arr[i+1];
                sorted_next[i+1] = arr[i];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (in_fire) begin
            // Slots above the write position hold the maximum so they sink to the end
            for (int i = 0; i < BASE_CHUNK_SIZE; i++) begin
                if (i > int'(cnt)) begin
                    arr[i] <= '1;
                end
            end
            arr[cnt] <= in_beat.data;
            if (in_beat.last) begin
                desc.n_chunks        <= 16'(chunk_count);
                desc.last_chunk_size <= (cnt == IDX_W'(BASE_CHUNK_SIZE - 1)) ?
                                        16'd0 : 16'(cnt) + 16'd1;
                desc.single          <= chunk_count == '0;
            end
        end else if (state == sort_pkg::chunk_sort) begin
            arr <= sorted_next;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state       <= sort_pkg::chunk_collect;
            cnt         <= '0;
            chunk_len   <= '0;
            pass_cnt    <= '0;
            drain_idx   <= '0;
            chunk_count <= '0;
            desc_valid  <= 1'b0;
        end else begin
            if (desc_valid && desc_ready) begin
                desc_valid <= 1'b0;
            end
            case (state)
                sort_pkg::chunk_collect: begin
                    if (in_fire) begin
                        cnt <= cnt + 1'b1;
                        if (chunk_end) begin
                            chunk_len <= {1'b0, cnt} + 1'b1;
                            pass_cnt  <= '0;
                            state     <= sort_pkg::chunk_sort;
                        end
                        if (in_beat.last) begin
                            desc_valid  <= 1'b1;
                            chunk_count <= '0;
                        end else if (chunk_end) begin
                            chunk_count <= chunk_count + 1'b1;
                        end
                    end
                end
                sort_pkg::chunk_sort: begin
                    pass_cnt <= pass_cnt + 1'b1;
                    if (pass_cnt == IDX_W'(BASE_CHUNK_SIZE - 1)) begin
                        drain_idx <= '0;
                        state     <= sort_pkg::chunk_drain;
                    end
                end
                default: begin
                    if (drain_fire) begin
                        drain_idx <= drain_idx + 1'b1;
                        if (chunk_beat.last) begin
                            cnt   <= '0;
                            state <= sort_pkg::chunk_collect;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/stream_fifo.sv
// Synchronous valid/ready FIFO for stream beats built on a circular buffer
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter int DEPTH = 32
) (
    input  logic                clock,
    input  logic                arst_n,
    input  sort_pkg::sort_beat_t in_beat,
    input  logic                in_valid,
    output logic                in_ready,
    output sort_pkg::sort_beat_t out_beat,
    output logic                out_valid,
    input  logic                out_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    sort_pkg::sort_beat_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready  = count != CNT_W'(DEPTH);
    assign out_valid = count != '0;
    assign out_beat  = mem[rd_ptr];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= in_beat;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // A simultaneous push and pop leaves the occupancy unchanged
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/sort_pkg.sv
// Shared element width, stream beat and job descriptor types, and FSM states of the sorter
`default_nettype none

package sort_pkg;

    // Width of one unsigned element
    parameter int DATA_WIDTH = 32;

    // One element on a stream link; valid and ready travel as separate ports
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  last;
    } sort_beat_t;

    // Shape of one job as seen by the merging unit
    typedef struct packed {
        // Number of chunks minus one
        logic [15:0] n_chunks;
        // Size of the final chunk, zero when that chunk is full
        logic [15:0] last_chunk_size;
        logic        single;
    } job_desc_t;

    typedef enum logic [1:0] {
        chunk_collect,
        chunk_sort,
        chunk_drain
    } chunk_state_e;

    typedef enum logic [1:0] {
        merge_idle,
        merge_bypass,
        merge_merging,
        merge_update_sizes
    } merge_state_e;

endpackage

`default_nettype wire
